/* design/thrd_defs.svh */
`ifndef THRD_DEFS_SVH
`define THRD_DEFS_SVH

// table capacity in threads
`define THRD_SLOTS 8

// thread payload widths
`define THRD_CTX_W 32
`define THRD_ADDR_W 16

// occupancy counter width, holds 0 .. THRD_SLOTS
`define THRD_CNT_W ($clog2(`THRD_SLOTS + 1))

// axi4-lite address width
`define THRD_AXI_AW 5

// register map, byte offsets
`define REG_CTX 5'h00
`define REG_ADDR 5'h04
`define REG_CMD 5'h08
`define REG_RESULT 5'h0C
`define REG_COUNT 5'h10

`endif

/* design/thrd_pkg.sv */
`default_nettype none

`include "thrd_defs.svh"

package thrd_pkg;

  // one thread, ctx in the upper bits
  typedef struct packed {
    logic [`THRD_CTX_W-1:0] ctx;
    logic [`THRD_ADDR_W-1:0] addr;
  } thrd_entry_t;

  // command codes, same values as written to REG_CMD
  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_RUN = 2'd1,
    OP_STOP = 2'd2
  } thrd_op_e;

  // command outcome
  typedef enum logic [2:0] {
    RSLT_NONE = 3'd0,
    RSLT_OK = 3'd1,
    RSLT_BUSY = 3'd2,
    RSLT_FULL = 3'd3,
    RSLT_NOT_FOUND = 3'd4
  } thrd_rslt_e;

endpackage

`default_nettype wire

/* design/thrd_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one run/stop command from the register block to the table
// transfer when valid and ready are both high, rslt valid in that cycle
interface thrd_cmd_if;
  import thrd_pkg::*;

  logic valid;
  thrd_op_e op;
  thrd_entry_t entry;
  logic ready;
  thrd_rslt_e rslt;

  // register side issues the command
  modport regs (
    output valid,
    output op,
    output entry,
    input ready,
    input rslt
  );

  // table side answers it
  modport tbl (
    input valid,
    input op,
    input entry,
    output ready,
    output rslt
  );

endinterface

`default_nettype wire

/* design/thrd_axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "thrd_defs.svh"

module thrd_axil_regs (
  input logic clk,
  input logic rst,
  // write address and data
  input logic [`THRD_AXI_AW-1:0] s_awaddr_i,
  input logic s_awvalid_i,
  output logic s_awready_o,
  input logic [31:0] s_wdata_i,
  input logic s_wvalid_i,
  output logic s_wready_o,
  // write response
  output logic [1:0] s_bresp_o,
  output logic s_bvalid_o,
  input logic s_bready_i,
  // read
  input logic [`THRD_AXI_AW-1:0] s_araddr_i,
  input logic s_arvalid_i,
  output logic s_arready_o,
  output logic [31:0] s_rdata_o,
  output logic [1:0] s_rresp_o,
  output logic s_rvalid_o,
  input logic s_rready_i,
  // command towards the table
  thrd_cmd_if.regs cmd,
  input logic [`THRD_CNT_W-1:0] count_i
);
  import thrd_pkg::*;

  typedef enum logic [1:0] {W_IDLE, W_ACC, W_CMD, W_RESP} wr_state_e;
  typedef enum logic [1:0] {R_IDLE, R_ACC, R_DATA} rd_state_e;

  wr_state_e wstate_q;
  rd_state_e rstate_q;

  // captured write beat
  logic [`THRD_AXI_AW-1:0] aw_addr_q;
  logic [31:0] w_data_q;
  // staged thread
  logic [`THRD_CTX_W-1:0] ctx_q;
  logic [`THRD_ADDR_W-1:0] addr_q;
  thrd_rslt_e result_q;

  logic [`THRD_AXI_AW-1:0] ar_addr_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_mux;

  logic is_cmd;
  logic op_ok;

  assign is_cmd = (aw_addr_q == `REG_CMD);
  // only run and stop start a command
  assign op_ok = (w_data_q == 32'(OP_RUN)) || (w_data_q == 32'(OP_STOP));

  // handshake outputs straight from state
  assign s_awready_o = (wstate_q == W_ACC);
  assign s_wready_o = (wstate_q == W_ACC);
  assign s_bvalid_o = (wstate_q == W_RESP);
  assign s_bresp_o = 2'b00;
  assign s_arready_o = (rstate_q == R_ACC);
  assign s_rvalid_o = (rstate_q == R_DATA);
  assign s_rresp_o = 2'b00;
  assign s_rdata_o = rdata_q;

  assign cmd.valid = (wstate_q == W_CMD);
  assign cmd.op = thrd_op_e'(w_data_q[1:0]);
  assign cmd.entry = '{ctx: ctx_q, addr: addr_q};

  // write channel fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      wstate_q <= W_IDLE;
      result_q <= RSLT_NONE;
    end else begin
      case (wstate_q)
        W_IDLE: begin
          // aw and w taken together
          if (s_awvalid_i && s_wvalid_i) begin
            wstate_q <= W_ACC;
          end
        end
        W_ACC: begin
          if (is_cmd && op_ok) begin
            wstate_q <= W_CMD;
          end else begin
            if (is_cmd) begin
              result_q <= RSLT_NONE;
            end
            wstate_q <= W_RESP;
          end
        end
        W_CMD: begin
          // hold valid until the table takes it
          if (cmd.ready) begin
            result_q <= cmd.rslt;
            wstate_q <= W_RESP;
          end
        end
        default: begin
          if (s_bready_i) begin
            wstate_q <= W_IDLE;
          end
        end
      endcase
    end
  end

  // write payload
  always_ff @(posedge clk) begin
    if (wstate_q == W_IDLE && s_awvalid_i && s_wvalid_i) begin
      aw_addr_q <= s_awaddr_i;
      w_data_q <= s_wdata_i;
    end
    if (wstate_q == W_ACC && aw_addr_q == `REG_CTX) begin
      ctx_q <= w_data_q[`THRD_CTX_W-1:0];
    end
    if (wstate_q == W_ACC && aw_addr_q == `REG_ADDR) begin
      addr_q <= w_data_q[`THRD_ADDR_W-1:0];
    end
  end

  // read mux, unmapped reads give zero
  always_comb begin
    rd_mux = '0;
    if (ar_addr_q == `REG_RESULT) begin
      rd_mux = 32'(result_q);
    end else if (ar_addr_q == `REG_COUNT) begin
      rd_mux = {{(32 - `THRD_CNT_W){1'b0}}, count_i};
    end
  end

  // read channel fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      rstate_q <= R_IDLE;
    end else begin
      case (rstate_q)
        R_IDLE: if (s_arvalid_i) rstate_q <= R_ACC;
        R_ACC: rstate_q <= R_DATA;
        default: if (s_rready_i) rstate_q <= R_IDLE;
      endcase
    end
  end

  // read payload
  always_ff @(posedge clk) begin
    if (rstate_q == R_IDLE && s_arvalid_i) begin
      ar_addr_q <= s_araddr_i;
    end
    if (rstate_q == R_ACC) begin
      rdata_q <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* design/thrd_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "thrd_defs.svh"

module thrd_table (
  input logic clk,
  input logic rst,
  // run/stop commands
  thrd_cmd_if.tbl cmd,
  // scheduling request
  input logic sched_req_i,
  output logic sched_ack_o,
  output logic next_valid_o,
  output thrd_pkg::thrd_entry_t next_entry_o,
  output logic [`THRD_CNT_W-1:0] count_o
);
  import thrd_pkg::*;

  localparam int IDX_W = $clog2(`THRD_SLOTS);
  localparam int CNT_W = `THRD_CNT_W;

  typedef enum logic {S_IDLE, S_SWAP} step_state_e;

  // active table, entries 0 .. count-1 valid
  thrd_entry_t tbl_q [`THRD_SLOTS];
  logic [CNT_W-1:0] count_q;
  logic [IDX_W-1:0] cursor_q;
  // pending run slot
  thrd_entry_t pend_q;
  logic pend_vld_q;
  // stop slot, address only
  logic [`THRD_ADDR_W-1:0] stop_addr_q;
  logic stop_vld_q;

  step_state_e state_q;
  logic ready_q;
  logic ack_q;
  logic next_valid_q;
  thrd_entry_t next_entry_q;

  logic found;
  thrd_rslt_e rslt_c;
  logic cmd_fire;
  logic run_ok;
  logic stop_ok;
  // slots as seen after this cycle's command
  logic pend_vld_c;
  thrd_entry_t pend_c;
  logic stop_vld_c;
  logic [`THRD_ADDR_W-1:0] stop_addr_c;

  logic step_go;
  logic swap_hit;
  logic take_pend;
  logic start_swap;
  logic take_cur;
  logic in_swap;
  logic [CNT_W-1:0] cnt_dec;
  logic [IDX_W-1:0] last_idx;
  thrd_entry_t moved;
  logic swap_wrap;
  logic [IDX_W-1:0] swap_idx;
  thrd_entry_t swap_out;

  // next cursor, wraps to 0 at cnt
  function automatic logic [IDX_W-1:0] adv(input logic [IDX_W-1:0] idx,
                                           input logic [CNT_W-1:0] cnt);
    logic [CNT_W-1:0] nxt;
    nxt = CNT_W'(idx) + 1'b1;
    return (nxt >= cnt) ? '0 : nxt[IDX_W-1:0];
  endfunction

  // look up the stop address among live entries
  always_comb begin
    found = 1'b0;
    for (int i = 0; i < `THRD_SLOTS; i++) begin
      if (CNT_W'(i) < count_q && tbl_q[i].addr == cmd.entry.addr) begin
        found = 1'b1;
      end
    end
  end

  // command outcome, checked in the transfer cycle
  always_comb begin
    rslt_c = RSLT_NONE;
    case (cmd.op)
      OP_RUN: begin
        if (pend_vld_q) rslt_c = RSLT_BUSY;
        else if (count_q >= CNT_W'(`THRD_SLOTS)) rslt_c = RSLT_FULL;
        else rslt_c = RSLT_OK;
      end
      OP_STOP: begin
        if (stop_vld_q) rslt_c = RSLT_BUSY;
        else if (!found) rslt_c = RSLT_NOT_FOUND;
        else rslt_c = RSLT_OK;
      end
      default: rslt_c = RSLT_NONE;
    endcase
  end

  assign cmd.ready = ready_q;
  assign cmd.rslt = rslt_c;

  assign cmd_fire = cmd.valid && ready_q;
  assign run_ok = cmd_fire && cmd.op == OP_RUN && rslt_c == RSLT_OK;
  assign stop_ok = cmd_fire && cmd.op == OP_STOP && rslt_c == RSLT_OK;

  // command goes first, a step in the same cycle sees it
  assign pend_vld_c = pend_vld_q || run_ok;
  assign pend_c = run_ok ? cmd.entry : pend_q;
  assign stop_vld_c = stop_vld_q || stop_ok;
  assign stop_addr_c = stop_ok ? cmd.entry.addr : stop_addr_q;

  // new step only once the previous ack is gone
  assign step_go = sched_req_i && !ack_q && state_q == S_IDLE;
  assign swap_hit = stop_vld_c && count_q != '0 && tbl_q[cursor_q].addr == stop_addr_c;
  assign take_pend = step_go && pend_vld_c;
  assign start_swap = step_go && !pend_vld_c && swap_hit;
  assign take_cur = step_go && !pend_vld_c && !swap_hit;
  assign in_swap = (state_q == S_SWAP);

  // swap-with-last removal
  assign cnt_dec = count_q - 1'b1;
  assign last_idx = cnt_dec[IDX_W-1:0];
  assign moved = tbl_q[last_idx];
  // removed slot was the last one, restart at the head
  assign swap_wrap = (CNT_W'(cursor_q) == cnt_dec);
  assign swap_idx = swap_wrap ? '0 : cursor_q;
  assign swap_out = swap_wrap ? tbl_q[0] : moved;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      ready_q <= 1'b0;
      state_q <= S_IDLE;
      count_q <= '0;
      cursor_q <= '0;
      pend_vld_q <= 1'b0;
      stop_vld_q <= 1'b0;
      ack_q <= 1'b0;
      next_valid_q <= 1'b0;
    end else begin
      // ready one cycle after valid, single cycle
      ready_q <= cmd.valid && !ready_q;
      pend_vld_q <= pend_vld_c && !take_pend;
      stop_vld_q <= stop_vld_c && !in_swap;
      ack_q <= take_pend || take_cur || in_swap;
      if (take_pend) begin
        next_valid_q <= 1'b1;
        count_q <= count_q + 1'b1;
      end
      if (take_cur) begin
        // empty table acks with nothing to run
        next_valid_q <= (count_q != '0);
        if (count_q != '0) cursor_q <= adv(cursor_q, count_q);
      end
      if (start_swap) begin
        state_q <= S_SWAP;
      end
      if (in_swap) begin
        count_q <= cnt_dec;
        next_valid_q <= (cnt_dec != '0);
        cursor_q <= adv(swap_idx, cnt_dec);
        state_q <= S_IDLE;
      end
    end
  end

  // table and slot payload
  always_ff @(posedge clk) begin
    if (run_ok) pend_q <= cmd.entry;
    if (stop_ok) stop_addr_q <= cmd.entry.addr;
    if (take_pend) begin
      // dispatch and append at the tail
      tbl_q[count_q[IDX_W-1:0]] <= pend_c;
      next_entry_q <= pend_c;
    end
    if (take_cur) next_entry_q <= tbl_q[cursor_q];
    if (in_swap) begin
      tbl_q[cursor_q] <= moved;
      next_entry_q <= swap_out;
    end
  end

  assign sched_ack_o = ack_q;
  assign next_valid_o = next_valid_q;
  assign next_entry_o = next_entry_q;
  assign count_o = count_q;

endmodule

`default_nettype wire

/* design/thrd_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "thrd_defs.svh"

module thrd_sched_top (
  input logic clk,
  input logic rst,
  // axi4-lite slave
  input logic [`THRD_AXI_AW-1:0] s_awaddr_i,
  input logic s_awvalid_i,
  output logic s_awready_o,
  input logic [31:0] s_wdata_i,
  input logic s_wvalid_i,
  output logic s_wready_o,
  output logic [1:0] s_bresp_o,
  output logic s_bvalid_o,
  input logic s_bready_i,
  input logic [`THRD_AXI_AW-1:0] s_araddr_i,
  input logic s_arvalid_i,
  output logic s_arready_o,
  output logic [31:0] s_rdata_o,
  output logic [1:0] s_rresp_o,
  output logic s_rvalid_o,
  input logic s_rready_i,
  // scheduling side
  input logic sched_req_i,
  output logic sched_ack_o,
  output logic next_valid_o,
  output logic [`THRD_ADDR_W-1:0] next_addr_o,
  output logic [`THRD_CTX_W-1:0] next_ctx_o,
  output logic [`THRD_CNT_W-1:0] thread_count_o
);
  import thrd_pkg::*;

  thrd_entry_t next_entry;
  logic [`THRD_CNT_W-1:0] count;

  // command path between register block and table
  thrd_cmd_if cmd_if ();

  thrd_axil_regs u_regs (
    .clk(clk),
    .rst(rst),
    .s_awaddr_i(s_awaddr_i),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i(s_wdata_i),
    .s_wvalid_i(s_wvalid_i),
    .s_wready_o(s_wready_o),
    .s_bresp_o(s_bresp_o),
    .s_bvalid_o(s_bvalid_o),
    .s_bready_i(s_bready_i),
    .s_araddr_i(s_araddr_i),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o(s_rdata_o),
    .s_rresp_o(s_rresp_o),
    .s_rvalid_o(s_rvalid_o),
    .s_rready_i(s_rready_i),
    .cmd(cmd_if.regs),
    .count_i(count)
  );

  thrd_table u_table (
    .clk(clk),
    .rst(rst),
    .cmd(cmd_if.tbl),
    .sched_req_i(sched_req_i),
    .sched_ack_o(sched_ack_o),
    .next_valid_o(next_valid_o),
    .next_entry_o(next_entry),
    .count_o(count)
  );

  // split the dispatched thread
  assign next_addr_o = next_entry.addr;
  assign next_ctx_o = next_entry.ctx;
  assign thread_count_o = count;

endmodule

`default_nettype wire

/* test/thrd_sched_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "thrd_defs.svh"

module thrd_sched_tb;
  import thrd_pkg::*;

  // action codes, upper nibble of a stimulus row
  localparam logic [3:0] ACT_RUN = 4'd1;
  localparam logic [3:0] ACT_STOP = 4'd2;
  localparam logic [3:0] ACT_STEP = 4'd3;
  localparam logic [3:0] ACT_COUNT = 4'd4;
  localparam int N_ROWS = 52;
  // worst row is three writes and a read
  localparam int ROW_CYCLES = 40;

  logic clk;
  logic rst;
  logic [`THRD_AXI_AW-1:0] aw_addr;
  logic aw_valid;
  logic aw_ready;
  logic [31:0] w_data;
  logic w_valid;
  logic w_ready;
  logic [1:0] b_resp;
  logic b_valid;
  logic b_ready;
  logic [`THRD_AXI_AW-1:0] ar_addr;
  logic ar_valid;
  logic ar_ready;
  logic [31:0] r_data;
  logic [1:0] r_resp;
  logic r_valid;
  logic r_ready;
  logic sched_req;
  logic sched_ack;
  logic next_valid;
  logic [`THRD_ADDR_W-1:0] next_addr;
  logic [`THRD_CTX_W-1:0] next_ctx;
  logic [`THRD_CNT_W-1:0] thread_count;

  // reference model of the table
  thrd_entry_t ref_tbl [`THRD_SLOTS];
  int ref_cnt;
  int ref_cur;
  logic ref_pend_vld;
  thrd_entry_t ref_pend;
  logic ref_stop_vld;
  logic [`THRD_ADDR_W-1:0] ref_stop_addr;
  logic [31:0] rng;
  int row_idx;

  // row is {action, thread address, expected}
  // expected holds the result code, the dispatched address or the count
  // a step expecting address 0 means an empty table
  logic [35:0] rows [N_ROWS] = '{
    // reset state, first run, busy pending slot
    36'h4_0000_0000, 36'h3_0000_0000, 36'h1_1001_0001, 36'h1_1002_0002,
    36'h3_0000_1001, 36'h4_0000_0001, 36'h1_1002_0001, 36'h3_0000_1002,
    // round robin with wrap
    36'h1_1003_0001, 36'h3_0000_1003, 36'h3_0000_1001, 36'h3_0000_1002,
    36'h3_0000_1003, 36'h3_0000_1001, 36'h4_0000_0003, 36'h1_1004_0001,
    36'h3_0000_1004, 36'h1_1005_0001, 36'h3_0000_1005, 36'h1_1006_0001,
    36'h3_0000_1006, 36'h1_1007_0001, 36'h3_0000_1007, 36'h1_1008_0001,
    // full table, then stop errors
    36'h3_0000_1008, 36'h1_1009_0003, 36'h4_0000_0008, 36'h2_2000_0004,
    36'h2_1005_0001, 36'h2_1003_0002, 36'h3_0000_1002, 36'h3_0000_1003,
    // A5 removed, A8 takes its place
    36'h3_0000_1004, 36'h3_0000_1008, 36'h4_0000_0007, 36'h3_0000_1006,
    36'h3_0000_1007, 36'h3_0000_1001, 36'h3_0000_1002, 36'h3_0000_1003,
    // removal of the last entry wraps to the head
    36'h3_0000_1004, 36'h3_0000_1008, 36'h2_1007_0001, 36'h3_0000_1006,
    36'h3_0000_1001, 36'h4_0000_0006, 36'h3_0000_1002, 36'h1_1005_0001,
    36'h3_0000_1005, 36'h3_0000_1003, 36'h4_0000_0007, 36'h3_0000_1004
  };

  thrd_sched_top thrd_sched_top_i (
    .clk(clk),
    .rst(rst),
    .s_awaddr_i(aw_addr),
    .s_awvalid_i(aw_valid),
    .s_awready_o(aw_ready),
    .s_wdata_i(w_data),
    .s_wvalid_i(w_valid),
    .s_wready_o(w_ready),
    .s_bresp_o(b_resp),
    .s_bvalid_o(b_valid),
    .s_bready_i(b_ready),
    .s_araddr_i(ar_addr),
    .s_arvalid_i(ar_valid),
    .s_arready_o(ar_ready),
    .s_rdata_o(r_data),
    .s_rresp_o(r_resp),
    .s_rvalid_o(r_valid),
    .s_rready_i(r_ready),
    .sched_req_i(sched_req),
    .sched_ack_o(sched_ack),
    .next_valid_o(next_valid),
    .next_addr_o(next_addr),
    .next_ctx_o(next_ctx),
    .thread_count_o(thread_count)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s (row %0d): got 0x%h, expected 0x%h", name, row_idx, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [`THRD_AXI_AW-1:0] a, input logic [31:0] d);
    aw_addr = a;
    w_data = d;
    aw_valid = 1'b1;
    w_valid = 1'b1;
    b_ready = 1'b1;
    next_cycle();
    while (!(aw_ready && w_ready)) next_cycle();
    // both taken at the coming edge
    next_cycle();
    aw_valid = 1'b0;
    w_valid = 1'b0;
    while (!b_valid) next_cycle();
    check_eq("s_bresp_o", 32'(b_resp), 32'h0);
    next_cycle();
    b_ready = 1'b0;
  endtask

  task automatic read_reg(input logic [`THRD_AXI_AW-1:0] a, output logic [31:0] d);
    ar_addr = a;
    ar_valid = 1'b1;
    r_ready = 1'b1;
    next_cycle();
    while (!ar_ready) next_cycle();
    next_cycle();
    ar_valid = 1'b0;
    while (!r_valid) next_cycle();
    d = r_data;
    check_eq("s_rresp_o", 32'(r_resp), 32'h0);
    next_cycle();
    r_ready = 1'b0;
  endtask

  // request held until ack, then one idle cycle so the ack drops
  task automatic sched_step(output logic vld, output logic [15:0] a, output logic [31:0] c,
                            output int lat);
    sched_req = 1'b1;
    next_cycle();
    lat = 1;
    while (!sched_ack) begin
      next_cycle();
      lat++;
    end
    vld = next_valid;
    a = next_addr;
    c = next_ctx;
    sched_req = 1'b0;
    next_cycle();
  endtask

  function automatic logic [31:0] run_expect(input thrd_entry_t e);
    if (ref_pend_vld) return 32'(RSLT_BUSY);
    // pending slot is free here, so only the table counts
    if (ref_cnt + 1 > `THRD_SLOTS) return 32'(RSLT_FULL);
    ref_pend_vld = 1'b1;
    ref_pend = e;
    return 32'(RSLT_OK);
  endfunction

  function automatic logic [31:0] stop_expect(input logic [`THRD_ADDR_W-1:0] a);
    logic hit;
    hit = 1'b0;
    if (ref_stop_vld) return 32'(RSLT_BUSY);
    for (int i = 0; i < ref_cnt; i++) begin
      if (ref_tbl[i].addr == a) hit = 1'b1;
    end
    if (!hit) return 32'(RSLT_NOT_FOUND);
    ref_stop_vld = 1'b1;
    ref_stop_addr = a;
    return 32'(RSLT_OK);
  endfunction

  task automatic step_expect(output logic vld, output thrd_entry_t e, output int lat);
    lat = 1;
    e = '0;
    if (ref_pend_vld) begin
      // pending thread goes first and joins the tail
      vld = 1'b1;
      e = ref_pend;
      ref_tbl[ref_cnt] = ref_pend;
      ref_cnt++;
      ref_pend_vld = 1'b0;
      return;
    end
    if (ref_stop_vld && ref_cnt > 0 && ref_tbl[ref_cur].addr == ref_stop_addr) begin
      // extra cycle to pull the last entry in
      ref_tbl[ref_cur] = ref_tbl[ref_cnt-1];
      ref_cnt--;
      ref_stop_vld = 1'b0;
      lat = 2;
      if (ref_cur == ref_cnt) ref_cur = 0;
    end
    vld = (ref_cnt != 0);
    if (vld) begin
      e = ref_tbl[ref_cur];
      ref_cur = (ref_cur + 1 >= ref_cnt) ? 0 : ref_cur + 1;
    end
  endtask

  initial begin
    logic [3:0] act;
    logic [15:0] addr;
    logic [31:0] exp;
    logic [31:0] rd;
    logic [31:0] ctx;
    logic [31:0] e_rslt;
    logic e_vld;
    thrd_entry_t e_ent;
    int e_lat;
    logic vld;
    logic [15:0] got_addr;
    logic [31:0] got_ctx;
    int lat;
    clk = 1'b0;
    rst = 1'b1;
    aw_addr = '0;
    aw_valid = 1'b0;
    w_data = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar_addr = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    sched_req = 1'b0;
    ref_cnt = 0;
    ref_cur = 0;
    ref_pend_vld = 1'b0;
    ref_pend = '0;
    ref_stop_vld = 1'b0;
    ref_stop_addr = '0;
    rng = 32'h9d33_17a8;
    row_idx = 0;
    next_cycle();
    next_cycle();
    rst = 1'b0;
    for (int r = 0; r < N_ROWS; r++) begin
      row_idx = r;
      act = rows[r][35:32];
      addr = rows[r][31:16];
      exp = 32'(rows[r][15:0]);
      case (act)
        ACT_RUN: begin
          rng = xorshift32(rng);
          ctx = rng;
          e_rslt = run_expect('{ctx: ctx, addr: addr});
          write_reg(`REG_CTX, ctx);
          write_reg(`REG_ADDR, 32'(addr));
          write_reg(`REG_CMD, 32'(OP_RUN));
          read_reg(`REG_RESULT, rd);
          check_eq("s_rdata_o result", rd, exp);
          check_eq("s_rdata_o result vs model", rd, e_rslt);
        end
        ACT_STOP: begin
          e_rslt = stop_expect(addr);
          write_reg(`REG_ADDR, 32'(addr));
          write_reg(`REG_CMD, 32'(OP_STOP));
          read_reg(`REG_RESULT, rd);
          check_eq("s_rdata_o result", rd, exp);
          check_eq("s_rdata_o result vs model", rd, e_rslt);
        end
        ACT_STEP: begin
          step_expect(e_vld, e_ent, e_lat);
          sched_step(vld, got_addr, got_ctx, lat);
          check_eq("next_valid_o", 32'(vld), 32'(exp != 0));
          check_eq("next_valid_o vs model", 32'(vld), 32'(e_vld));
          check_eq("sched_ack_o latency", 32'(lat), 32'(e_lat));
          if (e_vld) begin
            check_eq("next_addr_o", 32'(got_addr), exp);
            check_eq("next_addr_o vs model", 32'(got_addr), 32'(e_ent.addr));
            check_eq("next_ctx_o", got_ctx, e_ent.ctx);
          end
        end
        ACT_COUNT: begin
          read_reg(`REG_COUNT, rd);
          check_eq("s_rdata_o count", rd, exp);
          check_eq("s_rdata_o count vs model", rd, 32'(ref_cnt));
          check_eq("thread_count_o", 32'(thread_count), 32'(ref_cnt));
        end
        default: begin
          $display("stimulus row %0d has an unknown action code", r);
          $display("Some tests failed");
          $fatal(1);
        end
      endcase
    end
    $display("All tests passed");
    $finish;
  end

  // limit from the row count, plus reset
  initial begin
    #((N_ROWS * ROW_CYCLES + 20) * 20);
    $display("timeout: scheduler did not respond");
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/thrd_pkg.sv
design/thrd_cmd_if.sv
design/thrd_axil_regs.sv
design/thrd_table.sv
design/thrd_sched_top.sv
test/thrd_sched_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it, the exit status is the verdict
verilator --binary --timing -f sim.f --top-module thrd_sched_tb -o thrd_sched_sim \
  && ./obj_dir/thrd_sched_sim \
  || { echo "simulation did not complete cleanly"; exit 1; }
